//--- addrCounter.sv
`timescale 1ns/1ps

module addrCounter #(
    parameter  int DEPTH     = recordPkg::DEPTH,
    localparam int ADDR_BITS = $clog2(DEPTH + 1)
) (
    input  logic                 clk,
    input  logic                 resetN,
    input  recordPkg::fsmCmd_t   cmd,
    input  logic                 wordDone,
    output logic                 wrEn,
    output logic [ADDR_BITS-1:0] wrAddr,
    output logic [ADDR_BITS-1:0] rdAddr,
    output logic                 readDone
);
    logic full;

    assign full     = (wrAddr == ADDR_BITS'(DEPTH));
    assign wrEn     = wordDone && !full;     // Extra words are dropped
    assign readDone = (rdAddr == wrAddr);    // wrAddr doubles as word count

    always_ff @(posedge clk) begin
        if (!resetN || cmd.clearRecord) begin
            wrAddr <= '0;
            rdAddr <= '0;
        end else begin
            if (wrEn) wrAddr <= wrAddr + 1'b1;
            if (cmd.clearRead) begin
                rdAddr <= '0;
            end else if (cmd.stepRead && !readDone) begin
                rdAddr <= rdAddr + 1'b1;
            end
        end
    end

endmodule

//--- bitRecorder.sv
`timescale 1ns/1ps

module bitRecorder (
    input  logic                    clk,
    input  logic                    resetN,
    input  logic                    clear,
    input  logic                    samplePulse,
    input  logic                    dIn,
    output recordPkg::sampleWord_t  word,
    output logic                    wordDone,
    output recordPkg::partialWord_t partial
);
    localparam int W = recordPkg::WORD_BITS;

    recordPkg::sampleWord_t shiftReg;
    recordPkg::sampleWord_t shiftNext;
    logic [recordPkg::COUNT_BITS-1:0] bitCount;
    logic lastBit;

    assign shiftNext = {shiftReg[W-2:0], dIn};   // First bit walks up to the MSB
    assign lastBit   = samplePulse && !clear
                       && (bitCount == recordPkg::COUNT_BITS'(W - 1));

    // Left-align the collected bits for the scanner
    assign partial.bits  = shiftReg << (W - int'(bitCount));
    assign partial.count = bitCount;

    always_ff @(posedge clk) begin
        if (!resetN) begin
            bitCount <= '0;
            wordDone <= 1'b0;
        end else begin
            wordDone <= lastBit;                 // One cycle after the last sample
            if (lastBit) begin
                bitCount <= '0;
            end else if (samplePulse) begin
                bitCount <= clear ? recordPkg::COUNT_BITS'(1) : bitCount + 1'b1;
            end else if (clear) begin
                bitCount <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (samplePulse) shiftReg <= shiftNext;
        if (lastBit) word <= shiftNext;
    end

endmodule

//--- build.f
recordPkg.sv
bitRecorder.sv
addrCounter.sv
sampleStore.sv
zeroRunScanner.sv
recordFsm.sv
recordTop.sv
recordTop_chk.sv
tb_recordTop.sv

//--- recordFsm.sv
`timescale 1ns/1ps

module recordFsm (
    input  logic                     clk,
    input  logic                     resetN,
    input  logic                     enable,
    input  logic                     writeOut,
    input  logic                     determineOW,
    input  logic                     readDone,
    input  logic                     scanBusy,
    input  logic                     found,
    output recordPkg::fsmCmd_t       cmd,
    output recordPkg::recordStatus_t status,
    output logic                     pulseWrite
);
    typedef enum logic [3:0] {
        sIdle,
        sRecord,
        sCmdWait,
        sPbRead,
        sPbEmit,
        sChkRead,
        sChkLoad,
        sChkWait,
        sPartScan,
        sFinish
    } state_t;

    state_t state, nextState;

    always_ff @(posedge clk) begin
        if (!resetN) state <= sIdle;
        else         state <= nextState;
    end

    always_comb begin
        nextState  = state;
        cmd        = '0;
        pulseWrite = 1'b0;
        case (state)
            sIdle, sCmdWait: begin
                if (enable) begin
                    cmd.clearRecord = 1'b1;        // Fresh recording
                    nextState       = sRecord;
                end else if (state == sCmdWait && writeOut) begin
                    cmd.clearRead = 1'b1;
                    nextState     = sPbRead;
                end else if (state == sCmdWait && determineOW) begin
                    cmd.clearRead = 1'b1;
                    cmd.scanStart = 1'b1;
                    nextState     = sChkRead;
                end
            end
            sRecord: begin
                if (!enable) nextState = sCmdWait;  // Commands ignored until here
            end
            sPbRead: begin
                if (readDone) begin
                    nextState = sIdle;
                end else begin
                    cmd.stepRead = 1'b1;           // Read register samples old address
                    nextState    = sPbEmit;
                end
            end
            sPbEmit: begin
                pulseWrite = 1'b1;
                nextState  = sPbRead;
            end
            sChkRead: begin
                if (readDone) begin
                    cmd.scanLoadPartial = 1'b1;    // Stored words done, tail bits next
                    nextState           = sPartScan;
                end else begin
                    cmd.stepRead = 1'b1;
                    nextState    = sChkLoad;
                end
            end
            sChkLoad: begin
                cmd.scanLoadWord = 1'b1;
                nextState        = sChkWait;
            end
            sChkWait: begin
                if (found)          nextState = sFinish;
                else if (!scanBusy) nextState = sChkRead;
            end
            sPartScan: begin
                if (found || !scanBusy) nextState = sFinish;
            end
            sFinish: begin
                nextState = sIdle;
            end
            default: nextState = sIdle;
        endcase
    end

    // Verdict latched until the next recording
    always_ff @(posedge clk) begin
        if (!resetN || cmd.clearRecord) begin
            status <= '0;
        end else if (state == sFinish) begin
            status.owTrue   <= found;
            status.owReady  <= 1'b1;
            status.complete <= 1'b1;
        end
    end

endmodule

//--- recordPkg.sv
package recordPkg;

    localparam int WORD_BITS  = 32;
    localparam int DEPTH      = 16;      // Default store depth in words
    localparam int RUN_LEN    = 6;       // Zero run that means overwrite
    localparam int COUNT_BITS = $clog2(WORD_BITS + 1);

    typedef logic [WORD_BITS-1:0] sampleWord_t;

    // Unfinished word, valid bits left-aligned from the MSB
    typedef struct packed {
        logic [WORD_BITS-1:0]  bits;
        logic [COUNT_BITS-1:0] count;
    } partialWord_t;

    typedef struct packed {
        logic owTrue;
        logic owReady;
        logic complete;
    } recordStatus_t;

    typedef struct packed {
        logic clearRecord;      // Recorder and write counter
        logic clearRead;        // Read address back to 0
        logic stepRead;
        logic scanStart;        // Zero run state
        logic scanLoadWord;
        logic scanLoadPartial;
    } fsmCmd_t;

endpackage

//--- recordTop.sv
`timescale 1ns/1ps

module recordTop #(
    parameter int DEPTH   = recordPkg::DEPTH,
    parameter int RUN_LEN = recordPkg::RUN_LEN
) (
    input  logic                   clk,
    input  logic                   resetN,
    input  logic                   enable,
    input  logic                   samplePulse,
    input  logic                   dIn,
    input  logic                   writeOut,
    input  logic                   determineOW,
    output logic                   owTrue,
    output logic                   owReady,
    output logic                   complete,
    output logic                   pulseWrite,
    output recordPkg::sampleWord_t playbackOut
);
    localparam int ADDR_BITS = $clog2(DEPTH + 1);

    recordPkg::fsmCmd_t       cmd;
    recordPkg::recordStatus_t status;
    recordPkg::sampleWord_t   word;
    recordPkg::partialWord_t  partial;
    logic                     wordDone;
    logic                     wrEn;
    logic                     readDone;
    logic                     scanBusy;
    logic                     found;
    logic [ADDR_BITS-1:0]     wrAddr;
    logic [ADDR_BITS-1:0]     rdAddr;

    assign owTrue   = status.owTrue;
    assign owReady  = status.owReady;
    assign complete = status.complete;

    bitRecorder rec0 (.clk, .resetN, .clear(cmd.clearRecord),
        .samplePulse(samplePulse & enable), .dIn, .word, .wordDone, .partial);

    addrCounter #(.DEPTH(DEPTH)) addr0 (.clk, .resetN, .cmd, .wordDone, .wrEn,
        .wrAddr, .rdAddr, .readDone);

    sampleStore #(.DEPTH(DEPTH)) store0 (.clk, .wrEn, .wrAddr, .wrWord(word),
        .rdAddr, .rdWord(playbackOut));

    zeroRunScanner #(.RUN_LEN(RUN_LEN)) scan0 (.clk, .resetN, .cmd,
        .storedWord(playbackOut), .partial, .busy(scanBusy), .found);

    recordFsm fsm0 (.clk, .resetN, .enable, .writeOut, .determineOW, .readDone,
        .scanBusy, .found, .cmd, .status, .pulseWrite);

endmodule

//--- recordTop_chk.sv
`timescale 1ns/1ps

module recordTop_chk #(
    parameter  int DEPTH     = recordPkg::DEPTH,
    localparam int ADDR_BITS = $clog2(DEPTH + 1)
) (
    input logic                 clk,
    input logic                 resetN,
    input logic                 pulseWrite,
    input logic                 wrEn,
    input logic                 owTrue,
    input logic                 owReady,
    input logic                 complete,
    input logic [ADDR_BITS-1:0] wrAddr
);
    singlePulse: assert property (@(posedge clk) disable iff (!resetN)
        pulseWrite |=> !pulseWrite) else $error("pulseWrite high two cycles in a row");

    completeReady: assert property (@(posedge clk) disable iff (!resetN)
        complete |-> owReady) else $error("complete without owReady");

    noWriteWhenFull: assert property (@(posedge clk) disable iff (!resetN)
        wrEn |-> (wrAddr != ADDR_BITS'(DEPTH))) else $error("write into a full store");

    statusAfterReset: assert property (@(posedge clk)
        !resetN |=> !(owTrue || owReady || complete)) else $error("status set after reset");

endmodule

bind recordTop recordTop_chk #(.DEPTH(DEPTH)) chk0 (.clk, .resetN, .pulseWrite, .wrEn,
    .owTrue, .owReady, .complete, .wrAddr);

//--- runSim.sh
#!/bin/sh
# Compile and run the recorder testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_recordTop -o simv > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1
grep -q "^\*\* PASS \*\*$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

//--- sampleStore.sv
`timescale 1ns/1ps

module sampleStore #(
    parameter  int DEPTH     = recordPkg::DEPTH,
    localparam int ADDR_BITS = $clog2(DEPTH + 1),
    localparam int IDX_BITS  = $clog2(DEPTH)
) (
    input  logic                   clk,
    input  logic                   wrEn,
    input  logic [ADDR_BITS-1:0]   wrAddr,
    input  recordPkg::sampleWord_t wrWord,
    input  logic [ADDR_BITS-1:0]   rdAddr,
    output recordPkg::sampleWord_t rdWord
);
    recordPkg::sampleWord_t mem [DEPTH];

    logic [IDX_BITS-1:0] wrIdx;
    logic [IDX_BITS-1:0] rdIdx;

    // Count bit is dropped, wrEn is never set at DEPTH
    assign wrIdx = wrAddr[IDX_BITS-1:0];
    assign rdIdx = rdAddr[IDX_BITS-1:0];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrIdx] <= wrWord;
        end
    end

    // Read data one cycle behind the address
    always_ff @(posedge clk) begin
        rdWord <= mem[rdIdx];
    end

endmodule

//--- tb_recordTop.sv
`timescale 1ns/1ps

module tb_recordTop;
    localparam int DEPTH    = 16;
    localparam int RUN_LEN  = 6;
    localparam int W        = recordPkg::WORD_BITS;
    localparam int MAX_BITS = 1024;

    logic                   clk;
    logic                   resetN;
    logic                   enable;
    logic                   samplePulse;
    logic                   dIn;
    logic                   writeOut;
    logic                   determineOW;
    logic                   owTrue;
    logic                   owReady;
    logic                   complete;
    logic                   pulseWrite;
    recordPkg::sampleWord_t playbackOut;

    byte                    caseCmd[$];
    int                     caseBits[$];
    logic [MAX_BITS-1:0]    caseVec[$];
    logic                   caseOw[$];
    int                     caseCount[$];
    recordPkg::sampleWord_t fileWords[$];    // Expected words of all cases in file order

    recordPkg::sampleWord_t refWords[$];
    logic                   refOw;
    recordPkg::sampleWord_t gotWords[$];
    int                     totalBits;
    longint                 limitCycles;

    recordTop #(.DEPTH(DEPTH), .RUN_LEN(RUN_LEN)) dut0 (.clk, .resetN, .enable, .samplePulse,
        .dIn, .writeOut, .determineOW, .owTrue, .owReady, .complete, .pulseWrite,
        .playbackOut);

    always #50 clk = ~clk;

    always @(negedge clk) begin
        if (pulseWrite) gotWords.push_back(playbackOut);   // Mid-cycle capture
    end

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compareWord(input string what, input recordPkg::sampleWord_t got,
                               input recordPkg::sampleWord_t exp);
        if (got !== exp)
            stopOnError($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                                  $time, what, got, exp));
    endtask

    task automatic compareStatus(input string what, input recordPkg::recordStatus_t got,
                                 input recordPkg::recordStatus_t exp);
        if (got !== exp)
            stopOnError($sformatf("Mismatch at %0t ns: %s is %b, expected %b",
                                  $time, what, got, exp));
    endtask

    function automatic recordPkg::recordStatus_t currentStatus();
        recordPkg::recordStatus_t s;
        s.owTrue   = owTrue;
        s.owReady  = owReady;
        s.complete = complete;
        return s;
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #5;
    endtask

    task automatic readCases();
        int                     fd;
        int                     code;
        int                     nBits;
        int                     ow;
        int                     nWords;
        byte                    ch;
        byte                    bitCh;
        string                  line;
        logic [MAX_BITS-1:0]    vec;
        recordPkg::sampleWord_t w;
        fd = $fopen("testdata.txt", "r");
        if (fd == 0) stopOnError("Could not open testdata.txt");
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", ch);
            if (code != 1) break;
            if (ch == "#") begin
                code = $fgets(line, fd);               // Comment line
            end else begin
                code = $fscanf(fd, " %d", nBits);
                if (code != 1 || nBits < 0 || nBits > MAX_BITS)
                    stopOnError("Malformed case line in testdata.txt");
                vec = '0;
                for (int i = 0; i < nBits; i++) begin
                    code = $fscanf(fd, " %c", bitCh);  // Spaces inside the string are skipped
                    if (code != 1 || (bitCh != "0" && bitCh != "1"))
                        stopOnError("Malformed bit string in testdata.txt");
                    vec = {vec[MAX_BITS-2:0], bitCh == "1"};
                end
                code = $fscanf(fd, " %d %d", ow, nWords);
                if (code != 2) stopOnError("Malformed case line in testdata.txt");
                caseCmd.push_back(ch);
                caseBits.push_back(nBits);
                caseVec.push_back(vec);
                caseOw.push_back(ow[0]);
                caseCount.push_back(nWords);
                for (int i = 0; i < nWords; i++) begin
                    code = $fscanf(fd, " %h", w);
                    if (code != 1) stopOnError("Missing expected word in testdata.txt");
                    fileWords.push_back(w);
                end
            end
        end
        $fclose(fd);
    endtask

    // Reference model, first bit of the stream is the leftmost character
    task automatic buildReference(input logic [MAX_BITS-1:0] vec, input int nBits);
        int                     nFull;
        int                     nStored;
        int                     run;
        logic                   b;
        recordPkg::sampleWord_t w;
        nFull   = nBits / W;
        nStored = (nFull < DEPTH) ? nFull : DEPTH;
        refWords.delete();
        refOw = 1'b0;
        run   = 0;
        w     = '0;
        for (int i = 0; i < nBits; i++) begin
            b = vec[nBits - 1 - i];
            if (i < nStored * W || i >= nFull * W) begin   // Dropped words are skipped
                if (b) run = 0;
                else run++;
                if (run >= RUN_LEN) refOw = 1'b1;
            end
            if (i < nStored * W) begin
                w = {w[W-2:0], b};
                if (i % W == W - 1) refWords.push_back(w);
            end
        end
    endtask

    task automatic sendBits(input logic [MAX_BITS-1:0] vec, input int nBits);
        int gap;
        for (int i = 0; i < nBits; i++) begin
            samplePulse = 1'b1;
            dIn         = vec[nBits - 1 - i];
            nextCycle();
            samplePulse = 1'b0;
            gap         = $urandom_range(3, 0);
            repeat (gap) nextCycle();
        end
    endtask

    task automatic runCase(input int k, inout int fileIdx);
        int                       waitCycles;
        recordPkg::recordStatus_t expStatus;
        buildReference(caseVec[k], caseBits[k]);
        if (refWords.size() != caseCount[k])
            stopOnError($sformatf("Case %0d lists %0d words but the stream holds %0d",
                                  k, caseCount[k], refWords.size()));
        if (refOw !== caseOw[k])
            stopOnError($sformatf("Case %0d gives the wrong expected owTrue", k));
        foreach (refWords[i]) begin
            compareWord($sformatf("case %0d data file word %0d", k, i), fileWords[fileIdx],
                        refWords[i]);
            fileIdx++;
        end

        enable = 1'b1;                                 // Rising enable clears status
        repeat (3) nextCycle();
        compareStatus("status after new recording", currentStatus(), '0);
        sendBits(caseVec[k], caseBits[k]);
        gotWords.delete();
        writeOut = 1'b1;                               // Must be ignored while recording
        nextCycle();
        writeOut    = 1'b0;
        determineOW = 1'b1;
        nextCycle();
        determineOW = 1'b0;
        repeat (4) nextCycle();
        if (gotWords.size() != 0) stopOnError("pulseWrite strobed while enable was high");
        compareStatus("status while recording", currentStatus(), '0);
        enable = 1'b0;
        repeat (2) nextCycle();

        if (caseCmd[k] == "P") begin
            writeOut = 1'b1;
            nextCycle();
            writeOut   = 1'b0;
            waitCycles = 0;
            while (gotWords.size() < refWords.size() && waitCycles < 200) begin
                nextCycle();
                waitCycles++;
            end
            if (gotWords.size() < refWords.size())
                stopOnError($sformatf("Case %0d playback returned too few words", k));
            repeat (10) nextCycle();                   // No strobe may follow the last word
            if (gotWords.size() != refWords.size())
                stopOnError($sformatf("Case %0d playback returned extra words", k));
            foreach (refWords[i])
                compareWord($sformatf("case %0d playback word %0d", k, i), gotWords[i],
                            refWords[i]);
        end else begin
            determineOW = 1'b1;
            nextCycle();
            determineOW = 1'b0;
            waitCycles  = 0;
            while (!complete && waitCycles < 2000) begin
                nextCycle();
                waitCycles++;
            end
            if (!complete) stopOnError($sformatf("Case %0d overwrite check never completed", k));
            expStatus.owTrue   = refOw;
            expStatus.owReady  = 1'b1;
            expStatus.complete = 1'b1;
            compareStatus($sformatf("case %0d verdict", k), currentStatus(), expStatus);
        end
    endtask

    initial begin
        int seedDummy;
        int fileIdx;
        clk         = 1'b0;
        resetN      = 1'b0;
        enable      = 1'b0;
        samplePulse = 1'b0;
        dIn         = 1'b0;
        writeOut    = 1'b0;
        determineOW = 1'b0;
        seedDummy   = $urandom(32'h9914_26c3);
        readCases();
        totalBits = 0;
        foreach (caseBits[k]) totalBits += caseBits[k];
        limitCycles = longint'(totalBits) * 5 + caseCmd.size() * 1200 + 100;
        fork
            begin
                repeat (limitCycles) @(posedge clk);
                stopOnError("Watchdog expired before the tests finished");
            end
        join_none
        repeat (4) @(posedge clk);
        #5;
        resetN = 1'b1;
        nextCycle();
        compareStatus("status after reset", currentStatus(), '0);
        fileIdx = 0;
        foreach (caseCmd[k]) runCase(k, fileIdx);
        $display("** PASS **");
        $finish;
    end

endmodule

//--- testdata.txt
# Columns: command (P playback, D determine), bit count, bit string (first bit left),
#          expected owTrue, expected stored word count, expected words in hex
# Two words and six partial bits, a five zero run across the boundary
P 70 1010010111000011010110100011110000010010001101000101011001111000110101 0 2 A5C35A3C 12345678
# Seventeen words, only the first sixteen are kept
P 547 00010001000100010001000100010001001000100010001000100010001000100011001100110011001100110011001101000100010001000100010001000100010101010101010101010101010101010110011001100110011001100110011001110111011101110111011101110111100010001000100010001000100010001001100110011001100110011001100110101010101010101010101010101010101110111011101110111011101110111100110011001100110011001100110011011101110111011101110111011101111011101110111011101110111011101111111111111111111111111111111100010010001101000101011001111000101001011100001101011010001111001 01 0 16 11111111 22222222 33333333 44444444 55555555 66666666 77777777 88888888 99999999 AAAAAAAA BBBBBBBB CCCCCCCC DDDDDDDD EEEEEEEE FFFFFFFF 12345678
# Zero run of six across a word boundary
D 64 0101010101010101010101010101100000010101010101010101010101010101 1 2 55555558 15555555
# Zero run of six only in the partial bits
D 40 1111111111111111111111111111111110000001 1 1 FFFFFFFF
# Longest zero run is five
D 40 0101010101010101010101010100000110000011 0 1 55555541
# Partial bits only, holding a run of six
D 7 0000001 1 0
# Playback with an empty store
P 10 1100110011 0 0
# Same stream as the first case, five zeros across the boundary
D 70 1010010111000011010110100011110000010010001101000101011001111000110101 0 2 A5C35A3C 12345678

//--- zeroRunScanner.sv
`timescale 1ns/1ps

module zeroRunScanner #(
    parameter  int RUN_LEN  = recordPkg::RUN_LEN,
    localparam int RUN_BITS = $clog2(RUN_LEN + 1)
) (
    input  logic                    clk,
    input  logic                    resetN,
    input  recordPkg::fsmCmd_t      cmd,
    input  recordPkg::sampleWord_t  storedWord,
    input  recordPkg::partialWord_t partial,
    output logic                    busy,
    output logic                    found
);
    localparam int W = recordPkg::WORD_BITS;
    localparam logic [RUN_BITS-1:0] RUN_LAST = RUN_BITS'(RUN_LEN - 1);

    recordPkg::sampleWord_t shiftReg;
    logic [recordPkg::COUNT_BITS-1:0] bitsLeft;
    logic [RUN_BITS-1:0] zeroRun;
    logic nextBit;

    assign nextBit = shiftReg[W-1];                    // MSB goes first
    assign busy    = (bitsLeft != '0) && !found;       // Stops early on a hit

    always_ff @(posedge clk) begin
        if (!resetN || cmd.scanStart) begin
            bitsLeft <= '0;
            zeroRun  <= '0;
            found    <= 1'b0;
        end else if (cmd.scanLoadWord) begin
            bitsLeft <= recordPkg::COUNT_BITS'(W);
        end else if (cmd.scanLoadPartial) begin
            bitsLeft <= partial.count;
        end else if (busy) begin
            bitsLeft <= bitsLeft - 1'b1;
            if (nextBit) begin
                zeroRun <= '0;
            end else if (zeroRun == RUN_LAST) begin
                found <= 1'b1;
            end else begin
                zeroRun <= zeroRun + 1'b1;                 // Run carries across words
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.scanLoadWord) begin
            shiftReg <= storedWord;
        end else if (cmd.scanLoadPartial) begin
            shiftReg <= partial.bits;
        end else if (busy) begin
            shiftReg <= shiftReg << 1;
        end
    end

endmodule
